/* common/periph_bus_pkg.sv */
// bus side types shared by the router and the top level
`include "periph_defines.svh"

package periph_bus_pkg;

    // address and data words on the processor bus
    typedef logic [`PERIPH_DATA_W-1:0] bus_addr_t;
    typedef logic [`PERIPH_DATA_W-1:0] bus_data_t;

    // raw select field as taken from the address
    typedef logic [`PERIPH_SEL_W-1:0] sel_field_t;

    // decoded peripheral select
    // every code other than gpio and pwm decodes to SEL_NONE
    typedef enum logic [`PERIPH_SEL_W-1:0]
    {
        SEL_GPIO = 4'h0,    // gpio block
        SEL_PWM  = 4'h1,    // pwm generator
        SEL_NONE = 4'hf     // unmapped, reads zero
    } periph_sel_e;

endpackage : periph_bus_pkg

/* common/periph_defines.svh */
// peripheral subsystem parameters: widths, address fields and register offsets
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// bus widths
`define PERIPH_DATA_W       32      // data and address width
`define PERIPH_GPIO_W       8       // number of gpio lines
`define PERIPH_PWM_W        8       // pwm counter width

// address fields
`define PERIPH_SEL_LSB      8       // select field starts at addr[8]
`define PERIPH_SEL_W        4       // select field is addr[11:8]
`define PERIPH_OFF_W        4       // register offset is addr[3:0]

// gpio register offsets
`define PERIPH_REG_GPI      4'h0    // input lines, read only
`define PERIPH_REG_GPO      4'h1    // output register
`define PERIPH_REG_DIR      4'h2    // direction register

// pwm register offsets
`define PERIPH_REG_PERIOD   4'h0    // counter wraps after this value
`define PERIPH_REG_CMP      4'h1    // output high while counter below this

`endif

/* common/periph_dev_pkg.sv */
// device side types for the gpio and pwm peripherals
`include "periph_defines.svh"

package periph_dev_pkg;

    // one bit per gpio line
    typedef logic [`PERIPH_GPIO_W-1:0] gpio_vec_t;

    // pwm counter, period and compare values share one width
    typedef logic [`PERIPH_PWM_W-1:0] pwm_cnt_t;

    // register offset inside one peripheral
    typedef logic [`PERIPH_OFF_W-1:0] reg_off_t;

    // gpio register map
    typedef enum reg_off_t
    {
        REG_GPI = `PERIPH_REG_GPI,  // input lines
        REG_GPO = `PERIPH_REG_GPO,  // output value
        REG_DIR = `PERIPH_REG_DIR   // direction, 1 means output
    } gpio_reg_e;

    // pwm register map
    // offsets overlap with gpio, the select field tells them apart
    typedef enum reg_off_t
    {
        REG_PERIOD = `PERIPH_REG_PERIOD,
        REG_CMP    = `PERIPH_REG_CMP
    } pwm_reg_e;

endpackage : periph_dev_pkg

/* gpio/periph_gpio.sv */
// gpio block: output and direction registers plus a direct input read path
`include "periph_defines.svh"

module periph_gpio
(
    input  logic                       clk,
    input  logic                       resetn,
    // register access from the router
    input  periph_dev_pkg::reg_off_t   off_i,  // register offset
    input  logic                       we_i,   // write strobe, already decoded
    input  periph_bus_pkg::bus_data_t  wd_i,   // write data
    output periph_bus_pkg::bus_data_t  rd_o,   // read data, combinational
    // gpio lines
    input  periph_dev_pkg::gpio_vec_t  gpi_i,  // sampled straight, no sync
    output periph_dev_pkg::gpio_vec_t  gpo_o,  // output value
    output periph_dev_pkg::gpio_vec_t  gpd_o   // direction level
);

    localparam int PAD_W = `PERIPH_DATA_W - `PERIPH_GPIO_W; // zero extension width

    periph_dev_pkg::gpio_vec_t gpo_q;   // output register
    periph_dev_pkg::gpio_vec_t gpd_q;   // direction register
    periph_dev_pkg::gpio_vec_t wd_low;  // write data cut to gpio width
    logic                      gpo_we;
    logic                      gpd_we;

    assign wd_low = wd_i[`PERIPH_GPIO_W-1:0];

    // per register strobes, gpi has none so its writes fall away
    assign gpo_we = we_i && (off_i == periph_dev_pkg::REG_GPO);
    assign gpd_we = we_i && (off_i == periph_dev_pkg::REG_DIR);

    assign gpo_o = gpo_q;
    assign gpd_o = gpd_q;

    // read mux
    always_comb
    begin
        case (off_i)
            periph_dev_pkg::REG_GPO: rd_o = {{PAD_W{1'b0}}, gpo_q};
            periph_dev_pkg::REG_DIR: rd_o = {{PAD_W{1'b0}}, gpd_q};
            default:                 rd_o = {{PAD_W{1'b0}}, gpi_i}; // gpi and unknown
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin : load_gpo
        if (!resetn)
            gpo_q <= '0;
        else if (gpo_we)
            gpo_q <= wd_low;    // visible on gpo_o next cycle
    end

    always_ff @(posedge clk or negedge resetn)
    begin : load_gpd
        if (!resetn)
            gpd_q <= '0;
        else if (gpd_we)
            gpd_q <= wd_low;
    end

    // input register is read only
    // a write there must not disturb either stored register
    a_gpi_write_ignored : assert property (
        @(posedge clk) disable iff (!resetn)
        (we_i && off_i == periph_dev_pkg::REG_GPI) |=> ($stable(gpo_q) && $stable(gpd_q))
    ) else $error("gpio: write to input offset changed a register");

endmodule : periph_gpio

/* periph_sub.f */
+incdir+common
common/periph_bus_pkg.sv
common/periph_dev_pkg.sv
src/periph_bus_router.sv
gpio/periph_gpio.sv
pwm/periph_pwm.sv
src/periph_top.sv
testbench/tb_periph_checker.sv
testbench/tb_periph.sv

/* pwm/periph_pwm.sv */
// pwm generator: period and compare registers driving a free running counter
`include "periph_defines.svh"

module periph_pwm
(
    input  logic                       clk,
    input  logic                       resetn,
    // register access from the router
    input  periph_dev_pkg::reg_off_t   off_i,  // register offset
    input  logic                       we_i,   // write strobe, already decoded
    input  periph_bus_pkg::bus_data_t  wd_i,   // write data
    output periph_bus_pkg::bus_data_t  rd_o,   // read data, combinational
    // waveform
    output logic                       pwm_o   // registered pwm output
);

    localparam int PAD_W = `PERIPH_DATA_W - `PERIPH_PWM_W;

    periph_dev_pkg::pwm_cnt_t period_q;    // last counter value before wrap
    periph_dev_pkg::pwm_cnt_t cmp_q;       // high threshold
    periph_dev_pkg::pwm_cnt_t cnt_q;       // free running counter
    periph_dev_pkg::pwm_cnt_t wd_low;      // write data cut to counter width
    logic                     period_we;
    logic                     cmp_we;
    logic                     cnt_wrap;
    logic                     pwm_q;

    assign wd_low    = wd_i[`PERIPH_PWM_W-1:0];
    assign period_we = we_i && (off_i == periph_dev_pkg::REG_PERIOD);
    assign cmp_we    = we_i && (off_i == periph_dev_pkg::REG_CMP);
    assign cnt_wrap  = (cnt_q >= period_q);  // >= keeps it safe if period shrinks

    assign pwm_o = pwm_q;

    // read mux, unknown offsets expose the live counter
    always_comb
    begin
        case (off_i)
            periph_dev_pkg::REG_PERIOD: rd_o = {{PAD_W{1'b0}}, period_q};
            periph_dev_pkg::REG_CMP:    rd_o = {{PAD_W{1'b0}}, cmp_q};
            default:                    rd_o = {{PAD_W{1'b0}}, cnt_q};
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin : load_regs
        if (!resetn)
        begin
            period_q <= '0;
            cmp_q    <= '0;
        end
        else
        begin
            if (period_we)
                period_q <= wd_low;
            if (cmp_we)
                cmp_q <= wd_low;    // takes effect on the running period
        end
    end

    // counts 0..period, so one pwm cycle is period+1 clocks
    always_ff @(posedge clk or negedge resetn)
    begin : count
        if (!resetn)
            cnt_q <= '0;
        else if (period_we)
            cnt_q <= '0;    // restart cleanly on a new period
        else if (cnt_wrap)
            cnt_q <= '0;
        else
            cnt_q <= cnt_q + periph_dev_pkg::pwm_cnt_t'(1);
    end

    // output lags the compare by one clock
    always_ff @(posedge clk or negedge resetn)
    begin : out_reg
        if (!resetn)
            pwm_q <= 1'b0;
        else
            pwm_q <= (cnt_q < cmp_q);
    end

    a_cnt_in_period : assert property (
        @(posedge clk) disable iff (!resetn)
        cnt_q <= period_q
    ) else $error("pwm: counter %0d above period %0d", cnt_q, period_q);

endmodule : periph_pwm

/* run_sim.sh */
#!/bin/sh
# build and run the peripheral subsystem testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_periph -f periph_sub.f \
    -Mdir obj_dir -o sim_periph

./obj_dir/sim_periph | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

/* src/periph_bus_router.sv */
// bus router that decodes the select field, gates write strobes and muxes read data
`include "periph_defines.svh"

module periph_bus_router
(
    input  logic                       clk,        // assertions only
    input  logic                       resetn,     // assertions only
    // processor bus
    input  periph_bus_pkg::bus_addr_t  addr_i,
    input  logic                       we_i,
    input  periph_bus_pkg::bus_data_t  wd_i,
    output periph_bus_pkg::bus_data_t  rd_o,
    // shared to both peripherals
    output periph_dev_pkg::reg_off_t   off_o,      // addr[3:0]
    output periph_bus_pkg::bus_data_t  wd_o,
    // gpio
    output logic                       gpio_we_o,
    input  periph_bus_pkg::bus_data_t  gpio_rd_i,
    // pwm
    output logic                       pwm_we_o,
    input  periph_bus_pkg::bus_data_t  pwm_rd_i
);

    periph_bus_pkg::sel_field_t  sel_raw;  // addr[11:8] as is
    periph_bus_pkg::periph_sel_e sel;      // decoded target

    assign sel_raw = addr_i[`PERIPH_SEL_LSB +: `PERIPH_SEL_W];

    // fold every unmapped code onto SEL_NONE
    always_comb
    begin
        case (sel_raw)
            periph_bus_pkg::SEL_GPIO: sel = periph_bus_pkg::SEL_GPIO;
            periph_bus_pkg::SEL_PWM:  sel = periph_bus_pkg::SEL_PWM;
            default:                  sel = periph_bus_pkg::SEL_NONE;
        endcase
    end

    // peripherals only see the offset and the select stays here
    assign off_o = addr_i[`PERIPH_OFF_W-1:0];
    assign wd_o  = wd_i;

    assign gpio_we_o = we_i && (sel == periph_bus_pkg::SEL_GPIO);
    assign pwm_we_o  = we_i && (sel == periph_bus_pkg::SEL_PWM);

    // read data back from the selected block
    always_comb
    begin
        case (sel)
            periph_bus_pkg::SEL_GPIO: rd_o = gpio_rd_i;
            periph_bus_pkg::SEL_PWM:  rd_o = pwm_rd_i;
            default:                  rd_o = '0;  // unmapped reads zero
        endcase
    end

    a_one_hot_we : assert property (
        @(posedge clk) disable iff (!resetn)
        !(gpio_we_o && pwm_we_o)
    ) else $error("router: two write enables high at once");

    // raw address codes other than gpio and pwm must never reach a block
    a_no_we_unmapped : assert property (
        @(posedge clk) disable iff (!resetn)
        (sel_raw != periph_bus_pkg::SEL_GPIO && sel_raw != periph_bus_pkg::SEL_PWM)
            |-> !(gpio_we_o || pwm_we_o)
    ) else $error("router: write enable on unmapped select %0h", sel_raw);

endmodule : periph_bus_router

/* src/periph_top.sv */
// peripheral subsystem top: router with the gpio and pwm blocks behind it
`include "periph_defines.svh"

module periph_top
(
    input  logic                       clk,
    input  logic                       resetn,
    // processor bus
    input  periph_bus_pkg::bus_addr_t  addr_i,
    input  logic                       we_i,
    input  periph_bus_pkg::bus_data_t  wd_i,
    output periph_bus_pkg::bus_data_t  rd_o,
    // gpio lines
    input  periph_dev_pkg::gpio_vec_t  gpi_i,
    output periph_dev_pkg::gpio_vec_t  gpo_o,
    output periph_dev_pkg::gpio_vec_t  gpd_o,
    // pwm output
    output logic                       pwm_o
);

    periph_dev_pkg::reg_off_t  off;        // shared offset
    periph_bus_pkg::bus_data_t wd;         // shared write data
    logic                      gpio_we;
    periph_bus_pkg::bus_data_t gpio_rd;
    logic                      pwm_we;
    periph_bus_pkg::bus_data_t pwm_rd;

    periph_bus_router u_router
    (
        .clk        (clk),
        .resetn     (resetn),
        .addr_i     (addr_i),
        .we_i       (we_i),
        .wd_i       (wd_i),
        .rd_o       (rd_o),
        .off_o      (off),
        .wd_o       (wd),
        .gpio_we_o  (gpio_we),
        .gpio_rd_i  (gpio_rd),
        .pwm_we_o   (pwm_we),
        .pwm_rd_i   (pwm_rd)
    );

    periph_gpio u_gpio
    (
        .clk        (clk),
        .resetn     (resetn),
        .off_i      (off),
        .we_i       (gpio_we),
        .wd_i       (wd),
        .rd_o       (gpio_rd),
        .gpi_i      (gpi_i),
        .gpo_o      (gpo_o),
        .gpd_o      (gpd_o)
    );

    periph_pwm u_pwm
    (
        .clk        (clk),
        .resetn     (resetn),
        .off_i      (off),
        .we_i       (pwm_we),
        .wd_i       (wd),
        .rd_o       (pwm_rd),
        .pwm_o      (pwm_o)
    );

endmodule : periph_top

/* testbench/tb_periph.sv */
// testbench top: clock, reset, bus stimulus, reference model and watchdog
`include "periph_defines.svh"

module tb_periph;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;     // inputs change just after the edge
    localparam int RESET_CYC  = 8;
    localparam int N_GPIO     = 18;
    localparam int N_GPI      = 8;
    localparam int N_UNMAP    = 8;
    localparam int N_PWM      = 5;     // random period and compare pairs
    localparam int PWM_WINS   = 3;
    localparam int PWM_MAX_P  = 63;    // period kept to 6 bits
    // cycle budget of all tests for the watchdog
    localparam int RUN_CYC = RESET_CYC + 8 + N_GPIO * 4 + N_GPI * 2 + N_UNMAP * 8
                             + N_PWM * ((PWM_MAX_P + 1) * PWM_WINS + 6) + 8;
    localparam int MARGIN_CYC = 50;

    logic                      clk;
    logic                      resetn;
    periph_bus_pkg::bus_addr_t addr;
    logic                      we;
    periph_bus_pkg::bus_data_t wd;
    periph_bus_pkg::bus_data_t rd;
    periph_dev_pkg::gpio_vec_t gpi;
    periph_dev_pkg::gpio_vec_t gpo;
    periph_dev_pkg::gpio_vec_t gpd;
    logic                      pwm;

    integer seed = 84;

    // register model
    periph_dev_pkg::gpio_vec_t m_gpo;
    periph_dev_pkg::gpio_vec_t m_gpd;
    periph_dev_pkg::pwm_cnt_t  m_period;
    periph_dev_pkg::pwm_cnt_t  m_cmp;

    periph_top dut
    (
        .clk    (clk),
        .resetn (resetn),
        .addr_i (addr),
        .we_i   (we),
        .wd_i   (wd),
        .rd_o   (rd),
        .gpi_i  (gpi),
        .gpo_o  (gpo),
        .gpd_o  (gpd),
        .pwm_o  (pwm)
    );

    tb_periph_checker chk
    (
        .clk   (clk),
        .rd_i  (rd),
        .gpo_i (gpo),
        .gpd_i (gpd),
        .pwm_i (pwm)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic periph_bus_pkg::bus_data_t rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic periph_bus_pkg::bus_addr_t make_addr(input logic [3:0] sel,
                                                            input logic [3:0] off);
        make_addr = '0;
        make_addr[`PERIPH_SEL_LSB +: `PERIPH_SEL_W] = sel;
        make_addr[`PERIPH_OFF_W-1:0] = off;
    endfunction

    // expected read word from the address and the model
    function automatic periph_bus_pkg::bus_data_t expect_read(
        input periph_bus_pkg::bus_addr_t a, input periph_dev_pkg::gpio_vec_t lines);
        logic [`PERIPH_SEL_W-1:0]  sel;
        logic [`PERIPH_OFF_W-1:0]  off;
        periph_bus_pkg::bus_data_t word;
        sel  = a[`PERIPH_SEL_LSB +: `PERIPH_SEL_W];
        off  = a[`PERIPH_OFF_W-1:0];
        word = '0;                      // unmapped selects read zero
        if (sel == 4'h0)
        begin
            if (off == `PERIPH_REG_GPO)
                word[`PERIPH_GPIO_W-1:0] = m_gpo;
            else if (off == `PERIPH_REG_DIR)
                word[`PERIPH_GPIO_W-1:0] = m_gpd;
            else
                word[`PERIPH_GPIO_W-1:0] = lines;   // input offset and any unknown one
        end
        else if (sel == 4'h1)
        begin
            if (off == `PERIPH_REG_PERIOD)
                word[`PERIPH_PWM_W-1:0] = m_period;
            else if (off == `PERIPH_REG_CMP)
                word[`PERIPH_PWM_W-1:0] = m_cmp;
        end
        return word;
    endfunction

    // high clocks per period: compare value, at most the full period + 1
    function automatic int expect_high(input periph_dev_pkg::pwm_cnt_t period,
                                       input periph_dev_pkg::pwm_cnt_t cmp);
        int len;
        len = int'(period) + 1;
        return (int'(cmp) < len) ? int'(cmp) : len;
    endfunction

    task automatic bus_write(input periph_bus_pkg::bus_addr_t a,
                             input periph_bus_pkg::bus_data_t d);
        logic [`PERIPH_SEL_W-1:0] sel;
        logic [`PERIPH_OFF_W-1:0] off;
        sel  = a[`PERIPH_SEL_LSB +: `PERIPH_SEL_W];
        off  = a[`PERIPH_OFF_W-1:0];
        addr = a;
        wd   = d;
        we   = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        we = 1'b0;
        // model follows the register map, low bits only
        if (sel == 4'h0 && off == `PERIPH_REG_GPO)
            m_gpo = d[`PERIPH_GPIO_W-1:0];
        if (sel == 4'h0 && off == `PERIPH_REG_DIR)
            m_gpd = d[`PERIPH_GPIO_W-1:0];
        if (sel == 4'h1 && off == `PERIPH_REG_PERIOD)
            m_period = d[`PERIPH_PWM_W-1:0];
        if (sel == 4'h1 && off == `PERIPH_REG_CMP)
            m_cmp = d[`PERIPH_PWM_W-1:0];
    endtask

    task automatic check_read(input periph_bus_pkg::bus_addr_t a, input string tag);
        addr       = a;
        we         = 1'b0;
        chk.exp_rd = expect_read(a, gpi);
        chk.what   = tag;
        -> chk.rd_ev;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_pins(input string tag);
        chk.exp_gpo = m_gpo;
        chk.exp_gpd = m_gpd;
        chk.exp_pwm = 1'b0;
        chk.what    = tag;
        -> chk.pins_ev;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic end_test(input string name);
        chk.test_name = name;
        -> chk.test_end_ev;
    endtask

    initial
    begin : watchdog
        #((RUN_CYC + MARGIN_CYC) * CLK_PERIOD);
        $display("simulation timed out after %0d cycles", RUN_CYC + MARGIN_CYC);
        $display("Verification failed");
        $finish;
    end

    initial
    begin : stimulus
        periph_bus_pkg::bus_data_t d;
        logic [3:0]                sel;
        logic [3:0]                off;
        addr     = '0;
        we       = 1'b0;
        wd       = '0;
        gpi      = '0;
        resetn   = 1'b0;
        m_gpo    = '0;
        m_gpd    = '0;
        m_period = '0;
        m_cmp    = '0;
        chk.pwm_known = 1'b1;   // compare stays zero until the pwm test
        repeat (RESET_CYC) @(posedge clk);
        #DRIVE_DLY;
        resetn = 1'b1;
        d   = rand_word();
        gpi = d[`PERIPH_GPIO_W-1:0];

        check_pins("reset");
        check_read(make_addr(4'h0, `PERIPH_REG_GPI), "reset gpi");
        check_read(make_addr(4'h0, `PERIPH_REG_GPO), "reset gpo");
        check_read(make_addr(4'h0, `PERIPH_REG_DIR), "reset dir");
        check_read(make_addr(4'h1, `PERIPH_REG_PERIOD), "reset period");
        check_read(make_addr(4'h1, `PERIPH_REG_CMP), "reset cmp");
        end_test("reset values");

        for (int i = 0; i < N_GPIO; i++)
        begin
            case (i % 3)
                0:       off = `PERIPH_REG_GPO;
                1:       off = `PERIPH_REG_DIR;
                default: off = `PERIPH_REG_GPI;   // must change nothing
            endcase
            bus_write(make_addr(4'h0, off), rand_word());
            check_pins("gpio write");
            check_read(make_addr(4'h0, `PERIPH_REG_GPO), "gpo readback");
            check_read(make_addr(4'h0, `PERIPH_REG_DIR), "dir readback");
        end
        end_test("gpio writes");

        for (int i = 0; i < N_GPI; i++)
        begin
            d   = rand_word();
            gpi = d[`PERIPH_GPIO_W-1:0];
            off = (i % 2 == 0) ? `PERIPH_REG_GPI : 4'(i + 3);  // odd steps hit unknown offsets
            check_read(make_addr(4'h0, off), "gpi read");
        end
        end_test("gpio inputs");

        for (int i = 0; i < N_UNMAP; i++)
        begin
            d   = rand_word();
            sel = d[11:8];
            if (sel < 4'h2)
                sel = sel + 4'h2;
            off = {2'b00, d[1:0]};
            bus_write(make_addr(sel, off), rand_word());
            check_read(make_addr(sel, off), "unmapped read");
            check_read(make_addr(4'h0, `PERIPH_REG_GPO), "gpo after unmapped");
            check_read(make_addr(4'h0, `PERIPH_REG_DIR), "dir after unmapped");
            check_read(make_addr(4'h1, `PERIPH_REG_PERIOD), "period after unmapped");
            check_read(make_addr(4'h1, `PERIPH_REG_CMP), "cmp after unmapped");
            check_pins("unmapped write");
        end
        end_test("unmapped select");

        chk.pwm_known = 1'b0;
        for (int i = 0; i < N_PWM; i++)
        begin
            d    = rand_word();
            d[7] = 1'b0;                // compare often above the period
            bus_write(make_addr(4'h1, `PERIPH_REG_CMP), d);
            d      = rand_word();
            d[7:6] = 2'b00;
            bus_write(make_addr(4'h1, `PERIPH_REG_PERIOD), d);  // restarts the counter
            chk.exp_high = expect_high(m_period, m_cmp);
            chk.win_len  = int'(m_period) + 1;
            chk.win_cnt  = PWM_WINS;
            -> chk.pwm_ev;
            @(chk.pwm_done_ev);
            @(posedge clk);
            #DRIVE_DLY;
        end
        end_test("pwm duty");

        check_read(make_addr(4'h1, `PERIPH_REG_PERIOD), "period readback");
        check_read(make_addr(4'h1, `PERIPH_REG_CMP), "cmp readback");
        check_read(make_addr(4'h0, `PERIPH_REG_GPO), "gpo after pwm");
        check_read(make_addr(4'h0, `PERIPH_REG_DIR), "dir after pwm");
        check_pins("pins after pwm");
        end_test("pwm readback");

        @(posedge clk);
        chk.report_counts();
        if (chk.errors == 0 && chk.tests_failed == 0 && chk.checks > 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule : tb_periph

/* testbench/tb_periph_checker.sv */
// result checker: compares dut outputs against expected values sent by the testbench
`include "periph_defines.svh"

module tb_periph_checker
(
    input  logic                      clk,
    input  periph_bus_pkg::bus_data_t rd_i,
    input  periph_dev_pkg::gpio_vec_t gpo_i,
    input  periph_dev_pkg::gpio_vec_t gpd_i,
    input  logic                      pwm_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // expected values, loaded by the testbench right before it fires an event
    periph_bus_pkg::bus_data_t exp_rd;
    periph_dev_pkg::gpio_vec_t exp_gpo;
    periph_dev_pkg::gpio_vec_t exp_gpd;
    logic                      exp_pwm;
    logic                      pwm_known = 1'b0;  // level only checked while pwm is idle
    int                        exp_high;          // high clocks per pwm period
    int                        win_len;           // period + 1 clocks
    int                        win_cnt;           // windows to count
    string                     what;              // label of the current check
    string                     test_name;

    event rd_ev;
    event pins_ev;
    event pwm_ev;
    event pwm_done_ev;
    event test_end_ev;

    int checks       = 0;
    int errors       = 0;
    int test_errors  = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    task automatic check_word(input string tag, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            test_errors++;
            $display("** Error at %0d ns: %s expected %h got %h", $time, tag, exp, got);
        end
    endtask

    task automatic check_count(input string tag, input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            test_errors++;
            $display("** Error at %0d ns: %s expected %0d high clocks got %0d",
                     $time, tag, exp, got);
        end
    endtask

    // read word, sampled mid cycle once addr has settled
    always @(rd_ev)
    begin : cmp_rd
        periph_bus_pkg::bus_data_t exp;
        string                     tag;
        exp = exp_rd;
        tag = what;
        @(negedge clk);
        check_word(tag, rd_i, exp);
    end

    always @(pins_ev)
    begin : cmp_pins
        @(negedge clk);
        check_word({what, " gpo"}, 32'(gpo_i), 32'(exp_gpo));
        check_word({what, " dir"}, 32'(gpd_i), 32'(exp_gpd));
        if (pwm_known)
            check_word({what, " pwm"}, 32'(pwm_i), 32'(exp_pwm));
    end

    // counts pwm high clocks over whole periods
    always @(pwm_ev)
    begin : count_pwm
        int high;
        int len;
        int n;
        int expv;
        len  = win_len;
        n    = win_cnt;
        expv = exp_high;
        @(negedge clk);     // output still from before the restart
        for (int w = 0; w < n; w++)
        begin
            high = 0;
            repeat (len)
            begin
                @(negedge clk);
                if (pwm_i)
                    high++;
            end
            check_count($sformatf("pwm window %0d of period %0d", w, len), high, expv);
        end
        -> pwm_done_ev;
    end

    always @(test_end_ev)
    begin : close_test
        tests_run++;
        if (test_errors == 0)
            $display("test %0d %s: ok", tests_run, test_name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, test_name, test_errors);
        end
        test_errors = 0;
    end

    task automatic report_counts();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
    endtask

endmodule : tb_periph_checker
